// File: hdl/cpuPkg.sv
package cpuPkg;

    // Datapath and register file sizes.
    localparam int dataWidth    = 16;
    localparam int instrWidth   = 16;
    localparam int regAddrWidth = 3;
    localparam int numRegs      = 8;

    // The opcode field doubles as the ALU operation code.
    localparam int aluOpWidth = 5;
    localparam int functWidth = 2;

    // Instruction field positions.
    localparam int opcodeMsb = 15;
    localparam int opcodeLsb = 11;
    localparam int rdMsb     = 10;
    localparam int rdLsb     = 8;
    localparam int rsMsb     = 7;
    localparam int rsLsb     = 5;
    localparam int rtMsb     = 4;
    localparam int rtLsb     = 2;
    localparam int imm5Width = 5;
    localparam int imm8Width = 8;

    // Opcodes. Anything not listed here behaves like opNop.
    localparam logic [aluOpWidth-1:0] opNop   = 5'b00000;
    localparam logic [aluOpWidth-1:0] opRtype = 5'b00001;
    localparam logic [aluOpWidth-1:0] opAddi  = 5'b00010;
    localparam logic [aluOpWidth-1:0] opAndi  = 5'b00011;
    localparam logic [aluOpWidth-1:0] opSlli  = 5'b00100;
    localparam logic [aluOpWidth-1:0] opLbi   = 5'b00101;
    localparam logic [aluOpWidth-1:0] opHalt  = 5'b11111;

    // Register-register operations selected by funct under opRtype.
    localparam logic [functWidth-1:0] functAdd = 2'b00;
    localparam logic [functWidth-1:0] functSub = 2'b01;
    localparam logic [functWidth-1:0] functAnd = 2'b10;
    localparam logic [functWidth-1:0] functXor = 2'b11;

    // Shift amounts use only the low bits of imm5.
    localparam int shamtWidth = 4;

endpackage

// File: hdl/regFile.sv
`timescale 1ns/100ps

module regFile (
    input  logic                             clk,
    input  logic                             rstN,
    input  logic [cpuPkg::regAddrWidth-1:0]  readReg1,
    input  logic [cpuPkg::regAddrWidth-1:0]  readReg2,
    output logic [cpuPkg::dataWidth-1:0]     readData1,
    output logic [cpuPkg::dataWidth-1:0]     readData2,
    input  logic                             writeEn,
    input  logic [cpuPkg::regAddrWidth-1:0]  writeReg,
    input  logic [cpuPkg::dataWidth-1:0]     writeData
);

    logic [cpuPkg::dataWidth-1:0] regs [cpuPkg::numRegs];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            regs <= '{default: '0};
        end else if (writeEn) begin
            regs[writeReg] <= writeData;
        end
    end

    // Write-through so decode sees a value being written back this cycle.
    assign readData1 = (writeEn && (writeReg == readReg1)) ? writeData : regs[readReg1];
    assign readData2 = (writeEn && (writeReg == readReg2)) ? writeData : regs[readReg2];

endmodule

// File: hdl/decodeStage.sv
`timescale 1ns/100ps

module decodeStage (
    input  logic                             clk,
    input  logic                             rstN,
    input  logic                             frozen,
    input  logic                             instrValid,
    input  logic [cpuPkg::instrWidth-1:0]    instr,
    input  logic [cpuPkg::regAddrWidth-1:0]  exWriteReg,
    input  logic                             exWriteRegValid,
    input  logic [cpuPkg::dataWidth-1:0]     readData1,
    input  logic [cpuPkg::dataWidth-1:0]     readData2,
    output logic                             instrReady,
    output logic [cpuPkg::regAddrWidth-1:0]  readReg1,
    output logic [cpuPkg::regAddrWidth-1:0]  readReg2,
    output logic [cpuPkg::dataWidth-1:0]     rsData,
    output logic [cpuPkg::dataWidth-1:0]     rtData,
    output logic [cpuPkg::aluOpWidth-1:0]    aluOp,
    output logic [cpuPkg::functWidth-1:0]    funct,
    output logic                             aluSrc,
    output logic [cpuPkg::dataWidth-1:0]     immVal,
    output logic [cpuPkg::regAddrWidth-1:0]  writeReg,
    output logic                             regWrite,
    output logic                             halt,
    output logic [cpuPkg::regAddrWidth-1:0]  rs,
    output logic [cpuPkg::regAddrWidth-1:0]  rt,
    output logic                             rsValid,
    output logic                             rtValid,
    output logic                             writeRegValid,
    output logic                             controlZeroEmpty,
    output logic                             controlZeroHazard
);

    logic [cpuPkg::instrWidth-1:0] instrReg;
    logic                          occupied;
    logic                          haltTaken;
    logic                          accept;
    logic                          advance;
    logic                          rsHazard;
    logic                          rtHazard;
    logic [cpuPkg::dataWidth-1:0]  imm5Ext;
    logic [cpuPkg::dataWidth-1:0]  imm8Ext;

    assign aluOp    = instrReg[cpuPkg::opcodeMsb:cpuPkg::opcodeLsb];
    assign writeReg = instrReg[cpuPkg::rdMsb:cpuPkg::rdLsb];
    assign rs       = instrReg[cpuPkg::rsMsb:cpuPkg::rsLsb];
    assign rt       = instrReg[cpuPkg::rtMsb:cpuPkg::rtLsb];
    assign funct    = instrReg[cpuPkg::functWidth-1:0];
    assign readReg1 = rs;
    assign readReg2 = rt;

    assign imm5Ext = {{(cpuPkg::dataWidth - cpuPkg::imm5Width){instrReg[cpuPkg::imm5Width-1]}},
                      instrReg[cpuPkg::imm5Width-1:0]};
    assign imm8Ext = {{(cpuPkg::dataWidth - cpuPkg::imm8Width){instrReg[cpuPkg::imm8Width-1]}},
                      instrReg[cpuPkg::imm8Width-1:0]};

    always_comb begin
        aluSrc   = 1'b0;
        regWrite = 1'b0;
        halt     = 1'b0;
        rsValid  = 1'b0;
        rtValid  = 1'b0;
        immVal   = imm5Ext;
        case (aluOp)
            cpuPkg::opRtype: begin
                regWrite = 1'b1;
                rsValid  = 1'b1;
                rtValid  = 1'b1;
            end
            cpuPkg::opAddi, cpuPkg::opAndi, cpuPkg::opSlli: begin
                aluSrc   = 1'b1;
                regWrite = 1'b1;
                rsValid  = 1'b1;
            end
            cpuPkg::opLbi: begin
                aluSrc   = 1'b1;
                regWrite = 1'b1;
                immVal   = imm8Ext;
            end
            cpuPkg::opHalt: halt = 1'b1;
            default: ;  // Unknown opcodes write nothing.
        endcase
    end

    assign writeRegValid = regWrite;

    // Unused sources go out as zero so the ALU never sees stale register data.
    assign rsData = rsValid ? readData1 : '0;
    assign rtData = rtValid ? readData2 : '0;

    // A source that matches the destination still in execute must wait one cycle.
    assign rsHazard = rsValid && exWriteRegValid && (rs == exWriteReg);
    assign rtHazard = rtValid && exWriteRegValid && (rt == exWriteReg);

    assign controlZeroEmpty  = !occupied;
    assign controlZeroHazard = occupied && (rsHazard || rtHazard);

    assign advance    = occupied && !controlZeroHazard && !frozen;
    assign instrReady = !haltTaken && !frozen && !controlZeroHazard;
    assign accept     = instrValid && instrReady;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            occupied  <= 1'b0;
            haltTaken <= 1'b0;
        end else if (accept) begin
            occupied <= 1'b1;
            if (instr[cpuPkg::opcodeMsb:cpuPkg::opcodeLsb] == cpuPkg::opHalt) begin
                haltTaken <= 1'b1;  // No more words after a halt.
            end
        end else if (advance) begin
            occupied <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            instrReg <= instr;
        end
    end

endmodule

// File: hdl/idExReg.sv
`timescale 1ns/100ps

module idExReg (
    input  logic                             clk,
    input  logic                             rstN,
    input  logic                             frozen,
    input  logic                             controlZeroEmpty,
    input  logic                             controlZeroHazard,
    input  logic [cpuPkg::dataWidth-1:0]     readData1,
    input  logic [cpuPkg::dataWidth-1:0]     readData2,
    input  logic [cpuPkg::aluOpWidth-1:0]    aluOp,
    input  logic [cpuPkg::functWidth-1:0]    funct,
    input  logic                             aluSrc,
    input  logic [cpuPkg::dataWidth-1:0]     immVal,
    input  logic [cpuPkg::regAddrWidth-1:0]  writeReg,
    input  logic                             regWrite,
    input  logic                             halt,
    input  logic [cpuPkg::regAddrWidth-1:0]  rs,
    input  logic [cpuPkg::regAddrWidth-1:0]  rt,
    input  logic                             rsValid,
    input  logic                             rtValid,
    input  logic                             writeRegValid,
    output logic [cpuPkg::dataWidth-1:0]     readData1Out,
    output logic [cpuPkg::dataWidth-1:0]     readData2Out,
    output logic [cpuPkg::aluOpWidth-1:0]    aluOpOut,
    output logic [cpuPkg::functWidth-1:0]    functOut,
    output logic                             aluSrcOut,
    output logic [cpuPkg::dataWidth-1:0]     immValOut,
    output logic [cpuPkg::regAddrWidth-1:0]  writeRegOut,
    output logic                             regWriteOut,
    output logic                             haltOut,
    output logic [cpuPkg::regAddrWidth-1:0]  rsOut,
    output logic [cpuPkg::regAddrWidth-1:0]  rtOut,
    output logic                             rsValidOut,
    output logic                             rtValidOut,
    output logic                             writeRegValidOut
);

    logic controlZero;

    // Either bubble reason turns the slot into a no-op.
    assign controlZero = controlZeroEmpty || controlZeroHazard;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            aluOpOut         <= '0;
            functOut         <= '0;
            aluSrcOut        <= 1'b0;
            writeRegOut      <= '0;
            regWriteOut      <= 1'b0;
            haltOut          <= 1'b0;
            rsValidOut       <= 1'b0;
            rtValidOut       <= 1'b0;
            writeRegValidOut <= 1'b0;
        end else if (!frozen) begin
            aluOpOut         <= aluOp;
            functOut         <= funct;
            aluSrcOut        <= aluSrc;
            writeRegOut      <= writeReg;
            regWriteOut      <= controlZero ? 1'b0 : regWrite;
            haltOut          <= controlZero ? 1'b0 : halt;
            rsValidOut       <= rsValid;
            rtValidOut       <= rtValid;
            writeRegValidOut <= controlZero ? 1'b0 : writeRegValid;
        end
    end

    always_ff @(posedge clk) begin
        if (!frozen) begin
            readData1Out <= readData1;
            readData2Out <= readData2;
            immValOut    <= immVal;
            rsOut        <= rs;
            rtOut        <= rt;
        end
    end

endmodule

// File: hdl/executeStage.sv
`timescale 1ns/100ps

module executeStage (
    input  logic                             clk,
    input  logic                             rstN,
    input  logic                             wbReady,
    input  logic [cpuPkg::aluOpWidth-1:0]    aluOp,
    input  logic [cpuPkg::functWidth-1:0]    funct,
    input  logic                             aluSrc,
    input  logic [cpuPkg::dataWidth-1:0]     readData1,
    input  logic [cpuPkg::dataWidth-1:0]     readData2,
    input  logic [cpuPkg::dataWidth-1:0]     immVal,
    input  logic [cpuPkg::regAddrWidth-1:0]  writeReg,
    input  logic                             regWrite,
    input  logic                             halt,
    output logic                             wbValid,
    output logic [cpuPkg::regAddrWidth-1:0]  wbReg,
    output logic [cpuPkg::dataWidth-1:0]     wbData,
    output logic                             frozen,
    output logic                             halted
);

    logic [cpuPkg::dataWidth-1:0] opB;
    logic [cpuPkg::dataWidth-1:0] result;

    assign opB = aluSrc ? immVal : readData2;

    always_comb begin
        case (aluOp)
            cpuPkg::opRtype: begin
                case (funct)
                    cpuPkg::functAdd: result = readData1 + opB;
                    cpuPkg::functSub: result = readData1 - opB;
                    cpuPkg::functAnd: result = readData1 & opB;
                    default:          result = readData1 ^ opB;
                endcase
            end
            cpuPkg::opAddi: result = readData1 + opB;
            cpuPkg::opAndi: result = readData1 & opB;
            cpuPkg::opSlli: result = readData1 << opB[cpuPkg::shamtWidth-1:0];
            cpuPkg::opLbi:  result = opB;
            default:        result = '0;
        endcase
    end

    // A result the consumer has not taken stalls everything behind it.
    assign frozen = wbValid && !wbReady;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            wbValid <= 1'b0;
            halted  <= 1'b0;
        end else if (!frozen) begin
            wbValid <= regWrite;
            if (halt) begin
                halted <= 1'b1;  // Sticky until reset.
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!frozen) begin
            wbReg  <= writeReg;
            wbData <= result;
        end
    end

endmodule

// File: hdl/cpuCore.sv
`timescale 1ns/100ps

module cpuCore (
    input  logic                             clk,
    input  logic                             rstN,
    input  logic                             instrValid,
    input  logic [cpuPkg::instrWidth-1:0]    instr,
    output logic                             instrReady,
    output logic                             wbValid,
    output logic [cpuPkg::regAddrWidth-1:0]  wbReg,
    output logic [cpuPkg::dataWidth-1:0]     wbData,
    input  logic                             wbReady,
    output logic                             halted
);

    logic                            frozen;
    logic                            wbFire;
    logic [cpuPkg::regAddrWidth-1:0] readReg1, readReg2;
    logic [cpuPkg::dataWidth-1:0]    readData1, readData2;
    logic [cpuPkg::dataWidth-1:0]    rsData, rtData, immVal;
    logic [cpuPkg::aluOpWidth-1:0]   aluOp;
    logic [cpuPkg::functWidth-1:0]   funct;
    logic [cpuPkg::regAddrWidth-1:0] writeReg, rs, rt;
    logic                            aluSrc, regWrite, halt;
    logic                            rsValid, rtValid, writeRegValid;
    logic                            controlZeroEmpty, controlZeroHazard;
    logic [cpuPkg::dataWidth-1:0]    exData1, exData2, exImmVal;
    logic [cpuPkg::aluOpWidth-1:0]   exAluOp;
    logic [cpuPkg::functWidth-1:0]   exFunct;
    logic [cpuPkg::regAddrWidth-1:0] exWriteReg;
    logic                            exAluSrc, exRegWrite, exHalt, exWriteRegValid;

    assign wbFire = wbValid && wbReady;  // Register file write enable.

    regFile regFile_inst (
        .clk(clk), .rstN(rstN),
        .readReg1(readReg1), .readReg2(readReg2),
        .readData1(readData1), .readData2(readData2),
        .writeEn(wbFire), .writeReg(wbReg), .writeData(wbData)
    );

    decodeStage decodeStage_inst (
        .clk(clk), .rstN(rstN), .frozen(frozen),
        .instrValid(instrValid), .instr(instr),
        .exWriteReg(exWriteReg), .exWriteRegValid(exWriteRegValid),
        .readData1(readData1), .readData2(readData2),
        .instrReady(instrReady), .readReg1(readReg1), .readReg2(readReg2),
        .rsData(rsData), .rtData(rtData), .aluOp(aluOp), .funct(funct),
        .aluSrc(aluSrc), .immVal(immVal), .writeReg(writeReg),
        .regWrite(regWrite), .halt(halt), .rs(rs), .rt(rt),
        .rsValid(rsValid), .rtValid(rtValid), .writeRegValid(writeRegValid),
        .controlZeroEmpty(controlZeroEmpty), .controlZeroHazard(controlZeroHazard)
    );

    // Source tags are carried for debug visibility and not consumed downstream.
    idExReg idExReg_inst (
        .clk(clk), .rstN(rstN), .frozen(frozen),
        .controlZeroEmpty(controlZeroEmpty), .controlZeroHazard(controlZeroHazard),
        .readData1(rsData), .readData2(rtData), .aluOp(aluOp), .funct(funct),
        .aluSrc(aluSrc), .immVal(immVal), .writeReg(writeReg),
        .regWrite(regWrite), .halt(halt), .rs(rs), .rt(rt),
        .rsValid(rsValid), .rtValid(rtValid), .writeRegValid(writeRegValid),
        .readData1Out(exData1), .readData2Out(exData2), .aluOpOut(exAluOp),
        .functOut(exFunct), .aluSrcOut(exAluSrc), .immValOut(exImmVal),
        .writeRegOut(exWriteReg), .regWriteOut(exRegWrite), .haltOut(exHalt),
        .rsOut(), .rtOut(), .rsValidOut(), .rtValidOut(),
        .writeRegValidOut(exWriteRegValid)
    );

    executeStage executeStage_inst (
        .clk(clk), .rstN(rstN), .wbReady(wbReady),
        .aluOp(exAluOp), .funct(exFunct), .aluSrc(exAluSrc),
        .readData1(exData1), .readData2(exData2), .immVal(exImmVal),
        .writeReg(exWriteReg), .regWrite(exRegWrite), .halt(exHalt),
        .wbValid(wbValid), .wbReg(wbReg), .wbData(wbData),
        .frozen(frozen), .halted(halted)
    );

endmodule

// File: verif/cpuCore_props.sv
`timescale 1ns/100ps

module cpuCoreProps (
    input logic                            clk,
    input logic                            rstN,
    input logic                            instrReady,
    input logic                            wbValid,
    input logic                            wbReady,
    input logic [cpuPkg::regAddrWidth-1:0] wbReg,
    input logic [cpuPkg::dataWidth-1:0]    wbData,
    input logic                            halted
);

    // A result the consumer is holding off must not change.
    wbHoldCheck: assert property (@(posedge clk) disable iff (!rstN)
        (wbValid && !wbReady) |=> (wbValid && $stable(wbReg) && $stable(wbData)))
        else $error("wbReg or wbData changed while wbReady was low");

    resetCheck: assert property (@(posedge clk) !rstN |=> (!wbValid && !halted))
        else $error("wbValid or halted is high after reset");

    haltReadyCheck: assert property (@(posedge clk) disable iff (!rstN)
        halted |-> !instrReady)
        else $error("instrReady is high after the core halted");

endmodule

bind cpuCore cpuCoreProps cpuCoreProps_inst (.*);

// File: verif/cpuChecker.sv
`timescale 1ns/100ps

module cpuChecker (
    input  logic                            clk,
    input  logic                            rstN,
    input  logic                            instrValid,
    input  logic [cpuPkg::instrWidth-1:0]   instr,
    input  logic                            instrReady,
    input  logic                            wbValid,
    input  logic [cpuPkg::regAddrWidth-1:0] wbReg,
    input  logic [cpuPkg::dataWidth-1:0]    wbData,
    input  logic                            wbReady,
    input  logic                            halted,
    output int                              errorCount,
    output int                              checkedCount,
    output int                              pendingCount
);

    logic [cpuPkg::dataWidth-1:0] modelRegs [cpuPkg::numRegs];
    logic [18:0]                  expQ [$];  // Destination in 18..16, value below.
    logic [18:0]                  expected;
    logic                         haltTaken;
    logic                         haltedSeen;

    // Runs one accepted word in program order on the model registers.
    task automatic applyInstr(input logic [cpuPkg::instrWidth-1:0] word);
        logic [15:0] srcA, srcB, imm5, imm8, value;
        logic        writes;
        srcA   = modelRegs[word[7:5]];
        srcB   = modelRegs[word[4:2]];
        imm5   = {{11{word[4]}}, word[4:0]};
        imm8   = {{8{word[7]}}, word[7:0]};
        writes = 1'b1;
        value  = '0;
        case (word[15:11])
            cpuPkg::opRtype: begin
                case (word[1:0])
                    cpuPkg::functAdd: value = srcA + srcB;
                    cpuPkg::functSub: value = srcA - srcB;
                    cpuPkg::functAnd: value = srcA & srcB;
                    default:          value = srcA ^ srcB;
                endcase
            end
            cpuPkg::opAddi: value = srcA + imm5;
            cpuPkg::opAndi: value = srcA & imm5;
            cpuPkg::opSlli: value = srcA << imm5[3:0];
            cpuPkg::opLbi:  value = imm8;
            cpuPkg::opHalt: begin
                writes    = 1'b0;
                haltTaken = 1'b1;
            end
            default: writes = 1'b0;
        endcase
        if (writes) begin
            modelRegs[word[10:8]] = value;
            expQ.push_back({word[10:8], value});
        end
    endtask

    always @(posedge clk) begin
        if (!rstN) begin
            modelRegs    = '{default: '0};
            haltTaken    = 1'b0;
            haltedSeen   = 1'b0;
            errorCount   = 0;
            checkedCount = 0;
            expQ.delete();
        end else begin
            if (wbValid && wbReady) begin
                if (expQ.size() == 0) begin
                    $display("Extra writeback r%0d = 0x%h with no result pending", wbReg, wbData);
                    errorCount++;
                end else begin
                    expected = expQ.pop_front();
                    checkedCount++;
                    if (expected != {wbReg, wbData}) begin
                        $display("Fail alu: expected r%0d = 0x%h, actual r%0d = 0x%h",
                                 expected[18:16], expected[15:0], wbReg, wbData);
                        errorCount++;
                    end
                end
            end
            if (haltTaken && instrReady) begin
                $display("instrReady is high after the halt was accepted");
                errorCount++;
            end
            if (halted && !haltedSeen) begin
                haltedSeen = 1'b1;
                if (!haltTaken) begin
                    $display("halted rose before any halt was accepted");
                    errorCount++;
                end else if (expQ.size() != 0) begin
                    $display("halted rose with %0d writebacks still pending", expQ.size());
                    errorCount++;
                end
            end
            if (instrValid && instrReady) begin
                if (haltTaken) begin
                    $display("A word was accepted after the halt");
                    errorCount++;
                end
                applyInstr(instr);
            end
        end
        pendingCount = expQ.size();
    end

endmodule

// File: verif/cpuTb.sv
`timescale 1ns/100ps

module cpuTb;

    localparam int numInstrs     = 400;
    localparam int resetCycles   = 16;
    localparam int clkHalfPeriod = 10;
    localparam int timeoutCycles = resetCycles + (numInstrs + 1) * 10 + 500;
    localparam logic [31:0] seed = 32'hd875_e978;

    logic                            clk;
    logic                            rstN;
    logic                            instrValid;
    logic [cpuPkg::instrWidth-1:0]   instr;
    logic                            instrReady;
    logic                            wbValid;
    logic [cpuPkg::regAddrWidth-1:0] wbReg;
    logic [cpuPkg::dataWidth-1:0]    wbData;
    logic                            wbReady;
    logic                            halted;
    int                              errorCount, checkedCount, pendingCount;
    int                              endErrors;
    logic [31:0]                     stimState;
    logic [31:0]                     readyState;

    cpuCore cpuCore_inst (.*);
    cpuChecker cpuChecker_inst (.*);

    function automatic logic [31:0] lcgStep(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [15:0] nextStim();
        stimState = lcgStep(stimState);
        return stimState[31:16];  // The high bits of an LCG are the better ones.
    endfunction

    // Random word, often reading the register the previous word wrote.
    function automatic logic [cpuPkg::instrWidth-1:0] randomInstr(input logic [2:0] lastRd);
        logic [15:0] pick;
        logic [15:0] word;
        logic [4:0]  op;
        pick = nextStim();
        word = nextStim();
        case (pick[3:0])
            4'd0, 4'd1, 4'd2, 4'd3, 4'd4: op = cpuPkg::opRtype;
            4'd5, 4'd6:                   op = cpuPkg::opAddi;
            4'd7, 4'd8:                   op = cpuPkg::opAndi;
            4'd9, 4'd10:                  op = cpuPkg::opSlli;
            4'd11, 4'd12, 4'd13:          op = cpuPkg::opLbi;
            4'd14:                        op = cpuPkg::opNop;
            default:                      op = {2'b01, pick[6:4]};  // Unused opcodes.
        endcase
        if (pick[9]) word[7:5] = lastRd;
        if (pick[10] && pick[11]) word[4:2] = lastRd;
        word[15:11] = op;
        return word;
    endfunction

    task automatic sendWord(input logic [cpuPkg::instrWidth-1:0] word);
        logic [15:0] pick;
        pick = nextStim();
        while (pick[1:0] == 2'd0) begin
            instrValid <= 1'b0;
            @(posedge clk);
            pick = nextStim();
        end
        instrValid <= 1'b1;
        instr      <= word;
        @(posedge clk);
        while (!instrReady) @(posedge clk);
    endtask

    initial begin
        clk = 1'b0;
        forever #clkHalfPeriod clk = ~clk;
    end

    initial begin
        logic [15:0] r;
        readyState = ~seed;
        wbReady <= 1'b0;
        forever begin
            @(posedge clk);
            readyState = lcgStep(readyState);
            r = readyState[31:16];
            wbReady <= (r[1:0] != 2'd0);
        end
    end

    initial begin
        repeat (timeoutCycles) @(posedge clk);
        $display("Timeout after %0d cycles, the core never halted", timeoutCycles);
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin
        logic [cpuPkg::instrWidth-1:0]   word;
        logic [cpuPkg::regAddrWidth-1:0] lastRd;
        stimState  = seed;
        endErrors  = 0;
        lastRd     = '0;
        rstN       <= 1'b0;
        instrValid <= 1'b0;
        instr      <= '0;
        repeat (resetCycles) @(posedge clk);
        rstN <= 1'b1;
        for (int i = 0; i < numInstrs; i++) begin
            word   = randomInstr(lastRd);
            lastRd = word[10:8];
            sendWord(word);
        end
        sendWord({cpuPkg::opHalt, 11'd0});
        // Words keep coming after the halt, and the core must refuse every one.
        while (!halted) begin
            instr <= randomInstr(lastRd);
            @(posedge clk);
        end
        repeat (20) begin
            instr <= randomInstr(lastRd);
            @(posedge clk);
        end
        instrValid <= 1'b0;
        @(negedge clk);
        if (pendingCount != 0) begin
            $display("%0d expected writebacks never arrived", pendingCount);
            endErrors++;
        end
        if (checkedCount == 0) begin
            $display("No writeback was ever consumed");
            endErrors++;
        end
        $display("Writebacks checked %0d, checker errors %0d, end of run errors %0d",
                 checkedCount, errorCount, endErrors);
        if (errorCount + endErrors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// File: all.f
hdl/cpuPkg.sv
hdl/regFile.sv
hdl/decodeStage.sv
hdl/idExReg.sv
hdl/executeStage.sv
hdl/cpuCore.sv
verif/cpuCore_props.sv
verif/cpuChecker.sv
verif/cpuTb.sv

// File: run.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and looks for the pass message in the log.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert --top-module cpuTb -f all.f -o cpuSim > build.log 2>&1 \
    || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/cpuSim > sim.log 2>&1
cat sim.log
grep -qx "NO ERRORS" sim.log && { echo "Simulation passed"; exit 0; } \
    || { echo "Simulation failed"; exit 1; }
